//--- tlcs_alu_cfg.svh
//----------------------------------------------------------
// TLCS-900H ALU configuration
// datapath and divider widths shared by all blocks
//----------------------------------------------------------
`ifndef TLCS_ALU_CFG_SVH
`define TLCS_ALU_CFG_SVH

// one long word, the widest operand the ALU takes
`define ALU_W 32

// divisor width, also the quotient bit count at word size
`define DIV_W 16

`endif

//--- tlcs_alu_pkg.sv
//----------------------------------------------------------
// TLCS-900H ALU package
// operation codes, carry-in sources and the status flag set
//----------------------------------------------------------
`default_nettype none

package tlcs_alu_pkg;

    // encodings match the alu_sel field driven by the decoder
    typedef enum logic [4:0] {
        ADD  = 5'd0,
        SUB  = 5'd1,
        AND  = 5'd2,
        OR   = 5'd3,
        XOR  = 5'd4,
        CPL  = 5'd5,    // low 16 bits only
        SHL  = 5'd6,
        SHR  = 5'd7,
        MUL  = 5'd8,
        MULS = 5'd9,
        DIV  = 5'd10,
        DIVS = 5'd11,
        BAND = 5'd12,   // bit AND into carry
        BSET = 5'd13,
        MIRR = 5'd14,
        BS1B = 5'd15,   // highest set bit
        DAA  = 5'd16
    } alu_op_e;

    // where the carry-in of the current operation comes from
    typedef enum logic [2:0] {
        CIN  = 3'd0,    // stored carry
        COM  = 3'd1,    // inverted carry
        B0   = 3'd2,    // op0 bit 0
        HI   = 3'd3,
        ZF   = 3'd4,    // stored zero flag
        SA   = 3'd5,    // op2 sign at current size
        SH   = 3'd6,    // op2 bit 0
        ZERO = 3'd7
    } carry_e;

    // n is also read back as subtract mode by DAA
    typedef struct packed {
        logic n;
        logic h;
        logic z;
        logic v;
        logic c;
        logic p;
    } flags_t;

endpackage

`default_nettype wire

//--- alu_if.sv
//----------------------------------------------------------
// TLCS-900H ALU interfaces
// operand bundle into the core and the flag loop around it
//----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "tlcs_alu_cfg.svh"

interface alu_operand_if;
    logic [`ALU_W-1:0]     op0;        // destination
    logic [`ALU_W-1:0]     op1;        // source
    logic [`ALU_W-1:0]     op2;        // shift operand
    logic                  bs;         // byte size
    logic                  ws;         // word size, long when both low
    tlcs_alu_pkg::alu_op_e op_sel;
    tlcs_alu_pkg::carry_e  carry_sel;

    modport src (
        output op0, op1, op2,
        output bs, ws,
        output op_sel, carry_sel
    );

    modport dst (
        input op0, op1, op2,
        input bs, ws,
        input op_sel, carry_sel
    );
endinterface

interface alu_flag_if;
    tlcs_alu_pkg::flags_t raw;     // flags of the current result
    tlcs_alu_pkg::flags_t cur;     // stored flags

    modport calc (
        input  cur,
        output raw
    );

    modport store (
        input  raw,
        output cur
    );
endinterface

`default_nettype wire

//--- alu_div.sv
//----------------------------------------------------------
// TLCS-900H ALU divider
// restoring divide, one quotient bit per enabled cycle,
// 32/16 at word size and 16/8 at byte size
//----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "tlcs_alu_cfg.svh"

module alu_div (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              start,
    input  logic              len,         // high for word size
    input  logic              sign,
    input  logic [`ALU_W-1:0] dividend,
    input  logic [`DIV_W-1:0] divisor,
    output logic [`DIV_W-1:0] quot,
    output logic [`DIV_W-1:0] rem,
    output logic              busy,
    output logic              v
);

    localparam int HW = `DIV_W / 2;
    localparam int CW = $clog2(`DIV_W + 1);

    logic              sd, ss;          // operand signs
    logic [`ALU_W-1:0] dnd_mag;
    logic [`DIV_W-1:0] dvs_mag;
    logic [`DIV_W-1:0] rem_init, quo_init;
    logic [`DIV_W-1:0] rem_r, quo_r, dvs_r;
    logic [`DIV_W:0]   trial;
    logic [CW-1:0]     cnt;
    logic              len_r, sign_r, neg_q, neg_r, ovf_u;
    logic [`DIV_W-1:0] q_mag, q_lim;
    logic              sovf;

    // magnitudes, byte operands aligned into the word datapath
    always_comb begin
        sd = len ? dividend[`ALU_W-1] : dividend[`DIV_W-1];
        ss = len ? divisor[`DIV_W-1] : divisor[HW-1];
        if (len) begin
            dnd_mag  = (sign && sd) ? -dividend : dividend;
            dvs_mag  = (sign && ss) ? -divisor : divisor;
            rem_init = dnd_mag[`ALU_W-1:`DIV_W];
            quo_init = dnd_mag[`DIV_W-1:0];
        end else begin
            dnd_mag  = {{(`ALU_W-`DIV_W){1'b0}},
                        (sign && sd) ? -dividend[`DIV_W-1:0] : dividend[`DIV_W-1:0]};
            dvs_mag  = {{HW{1'b0}}, (sign && ss) ? -divisor[HW-1:0] : divisor[HW-1:0]};
            rem_init = {{HW{1'b0}}, dnd_mag[`DIV_W-1:HW]};
            quo_init = {dnd_mag[HW-1:0], {HW{1'b0}}};
        end
    end

    assign trial = {rem_r, quo_r[`DIV_W-1]} - {1'b0, dvs_r};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            cnt    <= '0;
            len_r  <= 1'b0;
            sign_r <= 1'b0;
            neg_q  <= 1'b0;
            neg_r  <= 1'b0;
            ovf_u  <= 1'b0;
        end else if (cen) begin
            if (start && !busy) begin
                busy   <= 1'b1;
                cnt    <= len ? CW'(`DIV_W) : CW'(HW);
                len_r  <= len;
                sign_r <= sign;
                neg_q  <= sign && (sd ^ ss);
                neg_r  <= sign && sd;
                ovf_u  <= rem_init >= dvs_mag;     // also catches a zero divisor
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == CW'(1))
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            if (start && !busy) begin
                rem_r <= rem_init;
                quo_r <= quo_init;
                dvs_r <= dvs_mag;
            end else if (busy) begin
                if (!trial[`DIV_W]) begin           // fits, keep the difference
                    rem_r <= trial[`DIV_W-1:0];
                    quo_r <= {quo_r[`DIV_W-2:0], 1'b1};
                end else begin                      // restore
                    rem_r <= {rem_r[`DIV_W-2:0], quo_r[`DIV_W-1]};
                    quo_r <= {quo_r[`DIV_W-2:0], 1'b0};
                end
            end
        end
    end

    // signed quotients must fit the signed range of the size
    always_comb begin
        q_mag = len_r ? quo_r : {{HW{1'b0}}, quo_r[HW-1:0]};
        q_lim = len_r ? {1'b1, {(`DIV_W-1){1'b0}}} : {{HW{1'b0}}, 1'b1, {(HW-1){1'b0}}};
        sovf  = neg_q ? (q_mag > q_lim) : (q_mag >= q_lim);
    end

    assign quot = neg_q ? -q_mag : q_mag;
    assign rem  = neg_r ? -rem_r : rem_r;  // sign of the dividend
    assign v    = ovf_u | (sign_r & sovf);

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst) busy |-> !start)
        else $error("divider started while busy");

endmodule

`default_nettype wire

//--- alu_core.sv
//----------------------------------------------------------
// TLCS-900H ALU core
// combinational result and raw flags, starts the divider
//----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "tlcs_alu_cfg.svh"

module alu_core (
    alu_operand_if.dst        ops,
    alu_flag_if.calc          flg,
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              div,
    output logic              div_busy,
    output logic [`ALU_W-1:0] rslt
);

    logic                     cx;            // selected carry-in
    logic                     sub;
    logic [`ALU_W-1:0]        opb;
    logic [`ALU_W-1:0]        sum;
    logic                     k0, k1, k2, k3;
    logic                     v8, v16, v32;
    logic [3:0]               bidx;
    logic                     bsel;
    logic [7:0]               daa;
    logic                     daa_hi, daa_lo, daa_c;
    logic [`ALU_W-1:0]        prod_u;
    logic signed [`ALU_W-1:0] prod_s;
    logic [`DIV_W-1:0]        div_quot, div_rem;
    logic                     div_v, div_sign;
    logic [`ALU_W-1:0]        rslt_c;
    logic [2:0]               cc;            // byte, word, long carry
    logic                     h, v;
    tlcs_alu_pkg::flags_t     raw_f;

    function automatic logic [3:0] msb_index(input logic [15:0] x);
        logic [3:0] idx;
        idx = 4'd0;
        for (int i = 0; i < 16; i++) begin
            if (x[i])
                idx = 4'(i);
        end
        return idx;
    endfunction

    function automatic logic [15:0] mirror16(input logic [15:0] x);
        logic [15:0] m;
        for (int i = 0; i < 16; i++)
            m[i] = x[15-i];
        return m;
    endfunction

    assign div_sign = ops.op_sel == tlcs_alu_pkg::DIVS;

    alu_div u_div (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .start    (div),
        .len      (~ops.bs),
        .sign     (div_sign),
        .dividend (ops.op0),
        .divisor  (ops.op1[`DIV_W-1:0]),
        .quot     (div_quot),
        .rem      (div_rem),
        .busy     (div_busy),
        .v        (div_v)
    );

    always_comb begin
        case (ops.carry_sel)
            tlcs_alu_pkg::CIN:  cx = flg.cur.c;
            tlcs_alu_pkg::COM:  cx = ~flg.cur.c;
            tlcs_alu_pkg::B0:   cx = ops.op0[0];
            tlcs_alu_pkg::HI:   cx = 1'b1;
            tlcs_alu_pkg::ZF:   cx = flg.cur.z;
            tlcs_alu_pkg::SA:   cx = ops.bs ? ops.op2[7] : ops.ws ? ops.op2[15] : ops.op2[31];
            tlcs_alu_pkg::SH:   cx = ops.op2[0];
            default:            cx = 1'b0;
        endcase
    end

    // subtract adds the inverted source, carry-in works as borrow
    always_comb begin
        sub = ops.op_sel == tlcs_alu_pkg::SUB;
        opb = sub ? ~ops.op1 : ops.op1;
        {k0, sum[3:0]}   = {1'b0, ops.op0[3:0]} + {1'b0, opb[3:0]} + {4'd0, cx ^ sub};
        {k1, sum[7:4]}   = {1'b0, ops.op0[7:4]} + {1'b0, opb[7:4]} + {4'd0, k0};
        {k2, sum[15:8]}  = {1'b0, ops.op0[15:8]} + {1'b0, opb[15:8]} + {8'd0, k1};
        {k3, sum[31:16]} = {1'b0, ops.op0[31:16]} + {1'b0, opb[31:16]} + {16'd0, k2};
        v8  = (ops.op0[7] == opb[7]) && (sum[7] != ops.op0[7]);
        v16 = (ops.op0[15] == opb[15]) && (sum[15] != ops.op0[15]);
        v32 = (ops.op0[31] == opb[31]) && (sum[31] != ops.op0[31]);
    end

    // correction for a decimal add, none after a subtract
    assign daa_hi = !flg.cur.n && (flg.cur.c || ops.op0[7:0] > 8'h99);
    assign daa_lo = !flg.cur.n && (flg.cur.h || ops.op0[3:0] > 4'd9);
    assign daa    = {daa_hi ? 4'h6 : 4'h0, daa_lo ? 4'h6 : 4'h0};
    assign daa_c  = flg.cur.n ? flg.cur.c : daa_hi;

    assign prod_u = ops.op0[15:0] * ops.op1[15:0];
    assign prod_s = $signed(ops.op0[15:0]) * $signed(ops.op1[15:0]);

    assign bidx = {ops.ws & ops.op1[3], ops.op1[2:0]};    // bit 0-7, or 0-15 on words
    assign bsel = ops.op0[bidx];

    always_comb begin
        rslt_c = ops.op0;
        cc     = {3{cx}};
        h      = 1'b0;
        v      = flg.cur.v;                  // kept unless the operation defines it
        case (ops.op_sel)
            tlcs_alu_pkg::ADD, tlcs_alu_pkg::SUB: begin
                rslt_c = sum;
                h      = k0 ^ sub;
                cc     = {k3, k2, k1} ^ {3{sub}};
                v      = ops.bs ? v8 : ops.ws ? v16 : v32;
            end
            tlcs_alu_pkg::AND:  rslt_c = ops.op0 & ops.op1;
            tlcs_alu_pkg::OR:   rslt_c = ops.op0 | ops.op1;
            tlcs_alu_pkg::XOR:  rslt_c = ops.op0 ^ ops.op1;
            tlcs_alu_pkg::CPL:  rslt_c[15:0] = ~ops.op0[15:0];
            tlcs_alu_pkg::SHL: begin
                rslt_c = {ops.op2[30:0], cx};
                cc     = {ops.op2[31], ops.op2[15], ops.op2[7]};
            end
            tlcs_alu_pkg::SHR: begin
                rslt_c = {cx, ops.op2[31:1]};
                if (ops.bs)
                    rslt_c[7] = cx;
                if (ops.ws)
                    rslt_c[15] = cx;
                cc = {3{ops.op2[0]}};
            end
            tlcs_alu_pkg::MUL:  rslt_c = prod_u;
            tlcs_alu_pkg::MULS: rslt_c = prod_s;
            tlcs_alu_pkg::DIV, tlcs_alu_pkg::DIVS: begin
                if (ops.bs)
                    rslt_c[15:0] = {div_rem[7:0], div_quot[7:0]};
                else
                    rslt_c = {div_rem, div_quot};
                v = div_v;
            end
            tlcs_alu_pkg::BAND: cc = {3{bsel & cx}};
            tlcs_alu_pkg::BSET: begin
                rslt_c[bidx] = cx;
                cc           = {3{~bsel}};
            end
            tlcs_alu_pkg::MIRR: rslt_c[15:0] = mirror16(ops.op0[15:0]);
            tlcs_alu_pkg::BS1B: begin
                rslt_c[7:0] = {4'd0, msb_index(ops.op0[15:0])};
                v           = ~|ops.op0[15:0];        // no bit set
            end
            tlcs_alu_pkg::DAA: begin
                rslt_c[7:0] = daa;
                cc          = {3{daa_c}};
            end
            default: ;
        endcase
    end

    always_comb begin
        raw_f.n = ops.bs ? rslt_c[7] : ops.ws ? rslt_c[15] : rslt_c[31];
        raw_f.h = h;
        raw_f.z = ops.bs ? rslt_c[7:0] == '0 : ops.ws ? rslt_c[15:0] == '0 : rslt_c == '0;
        raw_f.v = v;
        raw_f.c = ops.bs ? cc[0] : ops.ws ? cc[1] : cc[2];
        raw_f.p = ops.bs ? ~^rslt_c[7:0] : ~^rslt_c[15:0];    // even parity
    end

    assign flg.raw = raw_f;
    assign rslt    = rslt_c;

    a_one_size: assert property (@(posedge clk) disable iff (rst) !(ops.bs && ops.ws))
        else $error("byte and word size selected together");

endmodule

`default_nettype wire

//--- alu_flag_reg.sv
//----------------------------------------------------------
// TLCS-900H status flag register
// takes the ALU flags or a direct load, feeds them back
//----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module alu_flag_reg (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,
    input  logic                 flag_we,     // write from the ALU
    input  logic                 flag_load,   // direct load, wins over flag_we
    input  tlcs_alu_pkg::flags_t flag_in,
    alu_flag_if.store            flg
);

    tlcs_alu_pkg::flags_t cur_r;

    // raw v already carries the stored value when the op leaves it alone
    always_ff @(posedge clk) begin
        if (rst) begin
            cur_r <= '0;
        end else if (cen) begin
            if (flag_load)
                cur_r <= flag_in;
            else if (flag_we)
                cur_r <= flg.raw;
        end
    end

    assign flg.cur = cur_r;

    a_cur_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(flg.cur))
        else $error("stored flags hold unknown bits");

endmodule

`default_nettype wire

//--- alu_unit.sv
//----------------------------------------------------------
// TLCS-900H ALU subsystem top
// ALU core, divider and flag register on plain ports
//----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "tlcs_alu_cfg.svh"

module alu_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic [`ALU_W-1:0] op0,
    input  logic [`ALU_W-1:0] op1,
    input  logic [`ALU_W-1:0] op2,
    input  logic              bs,
    input  logic              ws,
    input  logic [4:0]        alu_sel,
    input  logic [2:0]        carry_sel,
    input  logic              div,
    input  logic              flag_we,
    input  logic              flag_load,
    input  logic [5:0]        flag_in,     // n h z v c p
    output logic              div_busy,
    output logic [`ALU_W-1:0] rslt,
    output logic [5:0]        flags
);

    alu_operand_if ops_if ();
    alu_flag_if    flg_if ();

    assign ops_if.op0       = op0;
    assign ops_if.op1       = op1;
    assign ops_if.op2       = op2;
    assign ops_if.bs        = bs;
    assign ops_if.ws        = ws;
    assign ops_if.op_sel    = tlcs_alu_pkg::alu_op_e'(alu_sel);
    assign ops_if.carry_sel = tlcs_alu_pkg::carry_e'(carry_sel);

    assign flags = flg_if.cur;

    alu_core u_core (
        .ops      (ops_if.dst),
        .flg      (flg_if.calc),
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .div      (div),
        .div_busy (div_busy),
        .rslt     (rslt)
    );

    alu_flag_reg u_flag_reg (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .flag_we   (flag_we),
        .flag_load (flag_load),
        .flag_in   (tlcs_alu_pkg::flags_t'(flag_in)),
        .flg       (flg_if.store)
    );

endmodule

`default_nettype wire

//--- tb_alu_unit.sv
//----------------------------------------------------------
// TLCS-900H ALU subsystem testbench
// table of operations with expected results and flags
//----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_alu_unit;

    localparam int MAXR = 96;
    localparam logic [4:0] OP_ADD = 5'd0, OP_SUB = 5'd1, OP_AND = 5'd2, OP_OR = 5'd3;
    localparam logic [4:0] OP_XOR = 5'd4, OP_CPL = 5'd5, OP_SHL = 5'd6, OP_SHR = 5'd7;
    localparam logic [4:0] OP_MUL = 5'd8, OP_MULS = 5'd9, OP_DIV = 5'd10, OP_DIVS = 5'd11;
    localparam logic [4:0] OP_BAND = 5'd12, OP_BSET = 5'd13, OP_MIRR = 5'd14;
    localparam logic [4:0] OP_BS1B = 5'd15, OP_DAA = 5'd16;
    localparam logic [1:0] SZ_L = 2'd0, SZ_W = 2'd1, SZ_B = 2'd2;

    logic        clk, rst, cen;
    logic [31:0] op0, op1, op2;
    logic        bs, ws;
    logic [4:0]  alu_sel;
    logic [2:0]  carry_sel;
    logic        div, flag_we, flag_load;
    logic [5:0]  flag_in;              // n h z v c p
    logic        div_busy;
    logic [31:0] rslt;
    logic [5:0]  flags;

    // stimulus table
    logic [4:0]  t_op[MAXR];
    logic [2:0]  t_cs[MAXR];
    logic [31:0] t_a[MAXR], t_b[MAXR], t_c[MAXR];
    logic [1:0]  t_sz[MAXR];
    logic [5:0]  t_pre[MAXR];
    logic [31:0] t_res[MAXR], t_rmask[MAXR];
    logic [5:0]  t_fl[MAXR], t_fmask[MAXR];
    int          num_rows;
    int          errors;
    logic [31:0] lfsr_q;
    logic        table_ready;

    alu_unit i_alu_unit (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .op0       (op0),
        .op1       (op1),
        .op2       (op2),
        .bs        (bs),
        .ws        (ws),
        .alu_sel   (alu_sel),
        .carry_sel (carry_sel),
        .div       (div),
        .flag_we   (flag_we),
        .flag_load (flag_load),
        .flag_in   (flag_in),
        .div_busy  (div_busy),
        .rslt      (rslt),
        .flags     (flags)
    );

    always #10 clk = ~clk;

    // fibonacci lfsr on taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], lfsr_q[0]};
        end
        return val;
    endfunction

    function automatic logic [2:0] nzp(input logic [31:0] r, input logic [1:0] sz);
        case (sz)
            SZ_B:    return {r[7], r[7:0] == 8'd0, ~^r[7:0]};
            SZ_W:    return {r[15], r[15:0] == 16'd0, ~^r[15:0]};
            default: return {r[31], r == 32'd0, ~^r[15:0]};
        endcase
    endfunction

    function automatic logic sel_carry(input logic [2:0] cs, input logic [5:0] pre,
                                       input logic [31:0] a, input logic [31:0] c,
                                       input logic [1:0] sz);
        case (cs)
            3'd0:    return pre[1];
            3'd1:    return ~pre[1];
            3'd2:    return a[0];
            3'd3:    return 1'b1;
            3'd4:    return pre[3];
            3'd5:    return sz == SZ_B ? c[7] : sz == SZ_W ? c[15] : c[31];
            3'd6:    return c[0];
            default: return 1'b0;
        endcase
    endfunction

    // reference flags for add and subtract at a given size
    function automatic logic [5:0] addsub_flags(input logic sub, input logic [31:0] a,
                                                input logic [31:0] b, input logic cx,
                                                input logic [1:0] sz, input logic [31:0] res);
        int          w;
        logic [63:0] m, aw, bw, t;
        logic        cy, h, v;
        logic [2:0]  f;
        w  = sz == SZ_B ? 8 : sz == SZ_W ? 16 : 32;
        m  = (64'd1 << w) - 64'd1;
        aw = {32'd0, a} & m;
        bw = {32'd0, b} & m;
        if (sub) begin
            cy = aw < bw + {63'd0, cx};
            h  = {1'b0, a[3:0]} < {1'b0, b[3:0]} + {4'd0, cx};
            v  = (a[w-1] != b[w-1]) && (res[w-1] != a[w-1]);
        end else begin
            t  = aw + bw + {63'd0, cx};
            cy = t[w];
            h  = ({1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cx}) > 5'd15;
            v  = (a[w-1] == b[w-1]) && (res[w-1] != a[w-1]);
        end
        f = nzp(res, sz);
        return {f[2], h, f[1], v, cy, f[0]};
    endfunction

    task automatic add_row(input logic [4:0] op, input logic [2:0] cs,
                           input logic [31:0] a, input logic [31:0] b, input logic [31:0] c,
                           input logic [1:0] sz, input logic [5:0] pre,
                           input logic [31:0] res, input logic [31:0] rmask,
                           input logic [5:0] fl, input logic [5:0] fmask);
        t_op[num_rows]  = op;
        t_cs[num_rows]  = cs;
        t_a[num_rows]   = a;
        t_b[num_rows]   = b;
        t_c[num_rows]   = c;
        t_sz[num_rows]  = sz;
        t_pre[num_rows] = pre;
        t_res[num_rows] = res;
        t_rmask[num_rows] = rmask;
        t_fl[num_rows]  = fl;
        t_fmask[num_rows] = fmask;
        num_rows++;
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp,
                         input logic [31:0] mask, input string what);
        if ((got & mask) !== (exp & mask)) begin
            errors++;
            $display("[ERROR] %0t ns: %s got %h expected %h (mask %h)",
                     $time, what, got, exp, mask);
        end
    endtask

    task automatic build_table();
        logic [4:0]  op;
        logic [2:0]  cs;
        logic [1:0]  sz;
        logic [5:0]  pre;
        logic [31:0] a, b, c, res, q, d, r;
        logic        cx;
        logic [2:0]  f;
        logic signed [31:0] ps;
        int          w;
        for (int i = 0; i < 24; i++) begin         // add and subtract
            op  = (i % 2) ? OP_SUB : OP_ADD;
            cs  = 3'((i / 2) % 8);
            sz  = 2'(i % 3);
            pre = 6'(rand_bits(6));
            a   = rand_bits(32);
            b   = rand_bits(32);
            c   = rand_bits(32);
            cx  = sel_carry(cs, pre, a, c, sz);
            res = (op == OP_SUB) ? a - b - {31'd0, cx} : a + b + {31'd0, cx};
            add_row(op, cs, a, b, c, sz, pre, res, '1,
                    addsub_flags(op == OP_SUB, a, b, cx, sz, res), 6'h3F);
        end
        for (int i = 0; i < 8; i++) begin          // logic ops
            op = 5'(OP_AND + 5'(i % 4));
            sz = 2'(i % 3);
            a  = rand_bits(32);
            b  = rand_bits(32);
            case (op)
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_XOR:  res = a ^ b;
                default: res = {a[31:16], ~a[15:0]};
            endcase
            f = nzp(res, sz);
            add_row(op, 3'd7, a, b, 32'd0, sz, 6'h00, res, '1,
                    {f[2], 1'b0, f[1], 2'b00, f[0]}, 6'b101001);
        end
        for (int i = 0; i < 8; i++) begin          // shifts
            op  = (i % 2) ? OP_SHR : OP_SHL;
            cs  = 3'(i);
            sz  = 2'(i % 3);
            w   = sz == SZ_B ? 8 : sz == SZ_W ? 16 : 32;
            pre = 6'(rand_bits(6));
            a   = rand_bits(32);
            c   = rand_bits(32);
            cx  = sel_carry(cs, pre, a, c, sz);
            if (op == OP_SHL) begin
                res = {c[30:0], cx};
                f   = nzp(res, sz);
                add_row(op, cs, a, 32'd0, c, sz, pre, res, '1,
                        {f[2], 1'b0, f[1], 1'b0, c[w-1], f[0]}, 6'b101011);
            end else begin
                res = {cx, c[31:1]};
                res[w-1] = cx;
                f   = nzp(res, sz);
                add_row(op, cs, a, 32'd0, c, sz, pre, res, '1,
                        {f[2], 1'b0, f[1], 1'b0, c[0], f[0]}, 6'b101011);
            end
        end
        for (int i = 0; i < 6; i++) begin          // multiplies
            a  = rand_bits(32);
            b  = rand_bits(32);
            ps = {{16{a[15]}}, a[15:0]} * {{16{b[15]}}, b[15:0]};
            if (i % 2)
                add_row(OP_MULS, 3'd7, a, b, 32'd0, SZ_L, 6'h00, ps, '1, 6'h00, 6'h00);
            else
                add_row(OP_MUL, 3'd7, a, b, 32'd0, SZ_L, 6'h00,
                        {16'd0, a[15:0]} * {16'd0, b[15:0]}, '1, 6'h00, 6'h00);
        end
        for (int i = 0; i < 4; i++) begin          // unsigned word divides
            q = rand_bits(16);
            d = rand_bits(16) | 32'd1;
            r = rand_bits(32) % d;
            add_row(OP_DIV, 3'd7, q * d + r, d, 32'd0, SZ_W, 6'h04,
                    {r[15:0], q[15:0]}, '1, 6'h00, 6'h04);
        end
        add_row(OP_DIV,  3'd7, 32'h1234_0064, 32'h7, 0, SZ_B, 6'h04, 32'h1234_020E, '1, 0, 6'h04);
        add_row(OP_DIVS, 3'd7, 32'h0000_FF9C, 32'h7, 0, SZ_B, 6'h04, 32'h0000_FEF2, '1, 0, 6'h04);
        add_row(OP_DIVS, 3'd7, 32'hFFFF_FC18, 32'h7, 0, SZ_W, 6'h04, 32'hFFFA_FF72, '1, 0, 6'h04);
        add_row(OP_DIVS, 3'd7, 32'h0000_03E8, 32'hFFF9, 0, SZ_W, 6'h04, 32'h0006_FF72, '1, 0, 6'h04);
        add_row(OP_DIV,  3'd7, 32'h0000_0005, 32'h0, 0, SZ_W, 6'h00, 0, 0, 6'h04, 6'h04);
        add_row(OP_DIV,  3'd7, 32'h0000_1000, 32'h2, 0, SZ_B, 6'h00, 0, 0, 6'h04, 6'h04);
        add_row(OP_DIVS, 3'd7, 32'h0000_00C8, 32'h1, 0, SZ_B, 6'h00, 0, 0, 6'h04, 6'h04);
        // bit operations, mirror, bit search, decimal adjust
        add_row(OP_BAND, 3'd3, 32'h0000_0020, 32'h5, 0, SZ_B, 6'h00, 32'h0000_0020, '1, 6'h02, 6'h02);
        add_row(OP_BAND, 3'd7, 32'h0000_0020, 32'h5, 0, SZ_B, 6'h02, 32'h0000_0020, '1, 6'h00, 6'h02);
        add_row(OP_BAND, 3'd3, 32'h0000_1000, 32'hC, 0, SZ_W, 6'h00, 32'h0000_1000, '1, 6'h02, 6'h02);
        add_row(OP_BSET, 3'd3, 32'h0000_00F0, 32'h2, 0, SZ_B, 6'h00, 32'h0000_00F4, '1, 6'h02, 6'h02);
        add_row(OP_BSET, 3'd7, 32'h0000_00F4, 32'h2, 0, SZ_B, 6'h02, 32'h0000_00F0, '1, 6'h00, 6'h02);
        add_row(OP_MIRR, 3'd7, 32'hABCD_0001, 32'h0, 0, SZ_W, 6'h00, 32'hABCD_8000, '1, 0, 0);
        add_row(OP_MIRR, 3'd7, 32'h0000_1234, 32'h0, 0, SZ_W, 6'h00, 32'h0000_2C48, '1, 0, 0);
        add_row(OP_BS1B, 3'd7, 32'h0000_0410, 32'h0, 0, SZ_W, 6'h04, 32'h0000_040A, '1, 6'h00, 6'h04);
        add_row(OP_BS1B, 3'd7, 32'h55AA_0000, 32'h0, 0, SZ_W, 6'h00, 32'h55AA_0000, '1, 6'h04, 6'h04);
        add_row(OP_DAA,  3'd7, 32'h0000_009C, 32'h0, 0, SZ_B, 6'h00, 32'h0000_0066, '1, 6'h02, 6'h02);
        add_row(OP_DAA,  3'd7, 32'h0000_0015, 32'h0, 0, SZ_B, 6'h10, 32'h0000_0006, '1, 6'h00, 6'h02);
        add_row(OP_DAA,  3'd7, 32'h0000_0099, 32'h0, 0, SZ_B, 6'h22, 32'h0000_0000, '1, 6'h02, 6'h02);
    endtask

    initial begin
        int wait_cnt;
        clk         = 1'b0;
        rst         = 1'b1;
        cen         = 1'b1;
        op0         = '0;
        op1         = '0;
        op2         = '0;
        bs          = 1'b0;
        ws          = 1'b0;
        alu_sel     = '0;
        carry_sel   = '0;
        div         = 1'b0;
        flag_we     = 1'b0;
        flag_load   = 1'b0;
        flag_in     = '0;
        errors      = 0;
        num_rows    = 0;
        table_ready = 1'b0;
        lfsr_q      = 32'h758;
        build_table();
        table_ready = 1'b1;

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check({26'd0, flags}, 32'd0, '1, "flags after reset");
        check({31'd0, div_busy}, 32'd0, '1, "div_busy after reset");

        // direct load beats the ALU write
        @(posedge clk);
        flag_in   <= 6'h2A;
        flag_load <= 1'b1;
        flag_we   <= 1'b1;
        @(posedge clk);
        flag_load <= 1'b0;
        flag_we   <= 1'b0;
        @(negedge clk);
        check({26'd0, flags}, 32'h2A, '1, "flag_load over flag_we");

        for (int i = 0; i < num_rows; i++) begin
            @(posedge clk);
            flag_in   <= t_pre[i];
            flag_load <= 1'b1;
            op0       <= t_a[i];
            op1       <= t_b[i];
            op2       <= t_c[i];
            bs        <= t_sz[i] == SZ_B;
            ws        <= t_sz[i] == SZ_W;
            alu_sel   <= t_op[i];
            carry_sel <= t_cs[i];
            @(posedge clk);
            flag_load <= 1'b0;
            if (t_op[i] == OP_DIV || t_op[i] == OP_DIVS) begin
                div <= 1'b1;
                @(posedge clk);
                div <= 1'b0;
                wait_cnt = 0;
                @(negedge clk);
                while (div_busy && wait_cnt < 40) begin
                    @(negedge clk);
                    wait_cnt++;
                end
                if (div_busy) begin
                    errors++;
                    $display("row %0d: divider stayed busy, it never finished", i);
                end
            end else begin
                @(negedge clk);
            end
            check(rslt, t_res[i], t_rmask[i], $sformatf("row %0d op %0d result", i, t_op[i]));
            @(posedge clk);
            flag_we <= 1'b1;
            @(posedge clk);
            flag_we <= 1'b0;
            @(negedge clk);
            check({26'd0, flags}, {26'd0, t_fl[i]}, {26'd0, t_fmask[i]},
                  $sformatf("row %0d op %0d flags", i, t_op[i]));
        end

        $display("rows run: %0d, errors: %0d", num_rows, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // about 40 cycles per row plus reset
    initial begin
        wait (table_ready);
        repeat ((num_rows + 12) * 40) @(posedge clk);
        $display("watchdog timeout: the table did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tlcs_alu.f
+incdir+.
tlcs_alu_pkg.sv
alu_if.sv
alu_div.sv
alu_core.sv
alu_flag_reg.sv
alu_unit.sv
tb_alu_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tlcs_alu.f --top-module tb_alu_unit -o sim_alu
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_alu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Simulation passed$"; then
    exit 0
fi
exit 1
